// File: common/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// --------------------------------------------------
// Address split of a 32-bit byte address.
// --------------------------------------------------
`define DCACHE_ADDR_W       32
`define DCACHE_OFFSET_W     3
`define DCACHE_OFFSET_LSB   2
`define DCACHE_INDEX_W      4
`define DCACHE_INDEX_LSB    5
`define DCACHE_TAG_W        23
`define DCACHE_TAG_LSB      9

// --------------------------------------------------
// Line geometry.
// --------------------------------------------------
`define DCACHE_LINE_W       256
`define DCACHE_WORDS        8
`define DCACHE_LINES        16
// One CPU word and its byte strobe.
`define DCACHE_WORD_W       32
`define DCACHE_STRB_W       4

`endif

// File: common/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // --------------------------------------------------
    // Controller states.
    // --------------------------------------------------
    typedef enum logic [2:0] {
        ST_IDLE         = 3'd0,
        ST_LOOKUP       = 3'd1,
        ST_DECIDE       = 3'd2,
        ST_REFILL_WAIT  = 3'd3,
        ST_REFILL_WRITE = 3'd4,
        ST_STORE_WAIT   = 3'd5,
        ST_RESPOND      = 3'd6
    } dcache_state_e;

    // --------------------------------------------------
    // CPU access opcodes.
    // --------------------------------------------------
    typedef enum logic [0:0] {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } dcache_op_e;

endpackage

`default_nettype wire

// File: common/dcache_array_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

interface dcache_array_if;

    // --------------------------------------------------
    // Request side, driven by the controller.
    // --------------------------------------------------
    // Address fields of the latched access.
    logic [`DCACHE_INDEX_W-1:0]  index;
    logic [`DCACHE_OFFSET_W-1:0] offset;
    logic [`DCACHE_TAG_W-1:0]    tag;
    // Register hit and selected word.
    logic                        rd_en;
    // Line refill from memory.
    logic                        fill_en;
    logic [`DCACHE_LINE_W-1:0]   fill_line;
    // Store merge into a cached line.
    logic                        st_en;
    logic [`DCACHE_WORD_W-1:0]   st_word;
    logic [`DCACHE_STRB_W-1:0]   st_strb;

    // --------------------------------------------------
    // Lookup result, driven by the array.
    // --------------------------------------------------
    logic                        hit;
    logic [`DCACHE_WORD_W-1:0]   rd_word;

    modport ctrl (
        output index, offset, tag, rd_en, fill_en, fill_line,
        output st_en, st_word, st_strb,
        input  hit, rd_word
    );

    modport array (
        input  index, offset, tag, rd_en, fill_en, fill_line,
        input  st_en, st_word, st_strb,
        output hit, rd_word
    );

endinterface

`default_nettype wire

// File: dcache/dcache_array.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_array (
    input  logic          clk,
    input  logic          reset,
    dcache_array_if.array arr
);

    // --------------------------------------------------
    // Storage.
    // --------------------------------------------------
    logic [`DCACHE_LINE_W-1:0] data_mem [`DCACHE_LINES];
    logic [`DCACHE_TAG_W-1:0]  tag_mem  [`DCACHE_LINES];
    logic [`DCACHE_LINES-1:0]  valid_q;

    // Lookup registers.
    logic                      hit_q;
    logic [`DCACHE_WORD_W-1:0] rd_word_q;

    // Datapath.
    logic [`DCACHE_WORDS-1:0]    word_hot;
    logic [`DCACHE_LINE_W-1:0]   cur_line;
    logic [`DCACHE_LINE_W-1:0]   src_line;
    logic [`DCACHE_WORD_W-1:0]   sel_word;
    logic                        hit_cmp;
    logic [`DCACHE_LINE_W/8-1:0] line_be;
    logic [`DCACHE_LINE_W-1:0]   merged_line;

    assign cur_line = data_mem[arr.index];

    // One-hot decode of the word offset.
    always_comb begin
        for (int w = 0; w < `DCACHE_WORDS; w++) begin
            word_hot[w] = (arr.offset == `DCACHE_OFFSET_W'(w));
        end
    end

    // During a refill the read sees the incoming line.
    assign src_line = arr.fill_en ? arr.fill_line : cur_line;

    // Each 32-bit slice gated by its hot bit, then OR-ed.
    always_comb begin
        sel_word = '0;
        for (int w = 0; w < `DCACHE_WORDS; w++) begin
            sel_word |= {`DCACHE_WORD_W{word_hot[w]}}
                        & src_line[w*`DCACHE_WORD_W +: `DCACHE_WORD_W];
        end
    end

    // Tag compare against the indexed entry.
    assign hit_cmp = valid_q[arr.index] && (tag_mem[arr.index] == arr.tag);

    // --------------------------------------------------
    // Store byte enables and merge.
    // --------------------------------------------------
    // Strobe lands only in the word at offset.
    always_comb begin
        for (int w = 0; w < `DCACHE_WORDS; w++) begin
            line_be[w*`DCACHE_STRB_W +: `DCACHE_STRB_W] =
                (word_hot[w] && arr.st_en) ? arr.st_strb : '0;
        end
    end

    always_comb begin
        merged_line = cur_line;
        for (int b = 0; b < `DCACHE_LINE_W/8; b++) begin
            if (line_be[b]) begin
                merged_line[b*8 +: 8] = arr.st_word[(b % `DCACHE_STRB_W)*8 +: 8];
            end
        end
    end

    // --------------------------------------------------
    // Writes.
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (arr.fill_en) begin
            data_mem[arr.index] <= arr.fill_line;
            tag_mem[arr.index]  <= arr.tag;
        end else if (arr.st_en) begin
            data_mem[arr.index] <= merged_line;
        end
    end

    // Valid bits clear on reset, set by a fill.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            hit_q   <= 1'b0;
        end else begin
            if (arr.fill_en) valid_q[arr.index] <= 1'b1;
            if (arr.rd_en) hit_q <= hit_cmp;
        end
    end

    // Selected word holds until the next read.
    always_ff @(posedge clk) begin
        if (arr.rd_en) rd_word_q <= sel_word;
    end

    assign arr.hit     = hit_q;
    assign arr.rd_word = rd_word_q;

    // Refill and store merge never share a cycle.
    a_fill_st_excl: assert property (@(posedge clk) disable iff (reset)
        !(arr.fill_en && arr.st_en));

endmodule

`default_nettype wire

// File: dcache/dcache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    // CPU side.
    input  logic                       req,
    input  dcache_pkg::dcache_op_e     op,
    input  logic [`DCACHE_ADDR_W-1:0]  addr,
    input  logic [`DCACHE_WORD_W-1:0]  wdata,
    input  logic [`DCACHE_STRB_W-1:0]  wstrb,
    output logic                       busy,
    output logic                       resp_valid,
    output logic                       resp_hit,
    output logic [`DCACHE_WORD_W-1:0]  rdata,
    // Memory side.
    output logic                       mem_rd_req,
    output logic [`DCACHE_ADDR_W-1:0]  mem_rd_addr,
    input  logic                       mem_rd_valid,
    input  logic [`DCACHE_LINE_W-1:0]  mem_rd_line,
    output logic                       mem_wr_req,
    output logic [`DCACHE_ADDR_W-1:0]  mem_wr_addr,
    output logic [`DCACHE_WORD_W-1:0]  mem_wr_data,
    output logic [`DCACHE_STRB_W-1:0]  mem_wr_strb,
    input  logic                       mem_wr_ack,
    // Array port.
    dcache_array_if.ctrl               arr
);

    import dcache_pkg::*;

    dcache_state_e state_q;
    dcache_state_e state_d;
    dcache_op_e    op_q;
    logic          hit_q;
    logic          accept;

    // Latched request payload.
    logic [`DCACHE_TAG_W-1:0]    tag_q;
    logic [`DCACHE_INDEX_W-1:0]  index_q;
    logic [`DCACHE_OFFSET_W-1:0] offset_q;
    logic [`DCACHE_WORD_W-1:0]   wdata_q;
    logic [`DCACHE_STRB_W-1:0]   wstrb_q;
    logic [`DCACHE_LINE_W-1:0]   fill_line_q;

    // A new access can start while idle or in the response cycle.
    assign accept = req && (state_q == ST_IDLE || state_q == ST_RESPOND);

    // --------------------------------------------------
    // Next state.
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:         if (accept) state_d = ST_LOOKUP;
            ST_LOOKUP:       state_d = ST_DECIDE;
            ST_DECIDE: begin
                if (op_q == OP_STORE) begin
                    state_d = ST_STORE_WAIT;
                end else if (arr.hit) begin
                    state_d = ST_RESPOND;
                end else begin
                    state_d = ST_REFILL_WAIT;
                end
            end
            ST_REFILL_WAIT:  if (mem_rd_valid) state_d = ST_REFILL_WRITE;
            ST_REFILL_WRITE: state_d = ST_RESPOND;
            ST_STORE_WAIT:   if (mem_wr_ack) state_d = ST_RESPOND;
            ST_RESPOND:      state_d = accept ? ST_LOOKUP : ST_IDLE;
            default:         state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_IDLE;
            op_q    <= OP_LOAD;
            hit_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) op_q <= op;
            // Lookup result is kept for the response.
            if (state_q == ST_DECIDE) hit_q <= arr.hit;
        end
    end

    // Split the address once at acceptance.
    always_ff @(posedge clk) begin
        if (accept) begin
            tag_q    <= addr[`DCACHE_TAG_LSB +: `DCACHE_TAG_W];
            index_q  <= addr[`DCACHE_INDEX_LSB +: `DCACHE_INDEX_W];
            offset_q <= addr[`DCACHE_OFFSET_LSB +: `DCACHE_OFFSET_W];
            wdata_q  <= wdata;
            wstrb_q  <= wstrb;
        end
        // Refill line only valid during the pulse.
        if (state_q == ST_REFILL_WAIT && mem_rd_valid) fill_line_q <= mem_rd_line;
    end

    // --------------------------------------------------
    // CPU and memory outputs.
    // --------------------------------------------------
    assign busy       = !(state_q == ST_IDLE || state_q == ST_RESPOND);
    assign resp_valid = (state_q == ST_RESPOND);
    assign resp_hit   = hit_q;
    assign rdata      = arr.rd_word;

    // Miss request and write-through leave from the decide cycle.
    assign mem_rd_req  = (state_q == ST_DECIDE) && (op_q == OP_LOAD) && !arr.hit;
    assign mem_wr_req  = (state_q == ST_DECIDE) && (op_q == OP_STORE);
    assign mem_rd_addr = {tag_q, index_q, {(`DCACHE_OFFSET_W + `DCACHE_OFFSET_LSB){1'b0}}};
    assign mem_wr_addr = {tag_q, index_q, offset_q, {`DCACHE_OFFSET_LSB{1'b0}}};
    assign mem_wr_data = wdata_q;
    assign mem_wr_strb = wstrb_q;

    // --------------------------------------------------
    // Array requests.
    // --------------------------------------------------
    assign arr.index     = index_q;
    assign arr.offset    = offset_q;
    assign arr.tag       = tag_q;
    // Second read picks the word out of the fresh line.
    assign arr.rd_en     = (state_q == ST_LOOKUP) || (state_q == ST_REFILL_WRITE);
    assign arr.fill_en   = (state_q == ST_REFILL_WRITE);
    assign arr.fill_line = fill_line_q;
    assign arr.st_en     = mem_wr_req && arr.hit;
    assign arr.st_word   = wdata_q;
    assign arr.st_strb   = wstrb_q;

    // CPU must wait for the response before the next request.
    a_no_req_when_busy: assert property (@(posedge clk) disable iff (reset)
        busy |-> !req);

    // One memory transaction at a time.
    a_one_mem_req: assert property (@(posedge clk) disable iff (reset)
        !(mem_rd_req && mem_wr_req));

endmodule

`default_nettype wire

// File: rtl/dcache_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_top (
    input  logic                       clk,
    input  logic                       reset,
    // --------------------------------------------------
    // CPU side.
    // --------------------------------------------------
    input  logic                       req,
    input  dcache_pkg::dcache_op_e     op,
    input  logic [`DCACHE_ADDR_W-1:0]  addr,
    input  logic [`DCACHE_WORD_W-1:0]  wdata,
    input  logic [`DCACHE_STRB_W-1:0]  wstrb,
    output logic                       busy,
    output logic                       resp_valid,
    output logic                       resp_hit,
    output logic [`DCACHE_WORD_W-1:0]  rdata,
    // --------------------------------------------------
    // Memory side.
    // --------------------------------------------------
    output logic                       mem_rd_req,
    output logic [`DCACHE_ADDR_W-1:0]  mem_rd_addr,
    input  logic                       mem_rd_valid,
    input  logic [`DCACHE_LINE_W-1:0]  mem_rd_line,
    output logic                       mem_wr_req,
    output logic [`DCACHE_ADDR_W-1:0]  mem_wr_addr,
    output logic [`DCACHE_WORD_W-1:0]  mem_wr_data,
    output logic [`DCACHE_STRB_W-1:0]  mem_wr_strb,
    input  logic                       mem_wr_ack
);

    // Controller to array link.
    dcache_array_if arr_if ();

    // Access sequencing and memory strobes.
    dcache_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .op           (op),
        .addr         (addr),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .busy         (busy),
        .resp_valid   (resp_valid),
        .resp_hit     (resp_hit),
        .rdata        (rdata),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_line  (mem_rd_line),
        .mem_wr_req   (mem_wr_req),
        .mem_wr_addr  (mem_wr_addr),
        .mem_wr_data  (mem_wr_data),
        .mem_wr_strb  (mem_wr_strb),
        .mem_wr_ack   (mem_wr_ack),
        .arr          (arr_if.ctrl)
    );

    // Tags, valid bits and line data.
    dcache_array u_array (
        .clk   (clk),
        .reset (reset),
        .arr   (arr_if.array)
    );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD_NS = 5;
    localparam int RESET_CYCLES   = 2;

    // Free-running 10 ns clock.
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD_NS clk = ~clk;
    end

    // Reset held high for the first edges.
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: verification/tb_dcache.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_settings.svh"

module tb_dcache;

    import dcache_pkg::*;

    localparam int RANDOM_ACCESSES = 300;
    localparam int TIMEOUT_CYCLES  = 400 * RANDOM_ACCESSES + 2000;
    localparam int HIT_LATENCY     = 3;
    localparam int MEM_WORDS       = 1024;

    // Expected outcome of one access, queued at the accepting edge.
    typedef struct packed {
        logic        is_store;
        logic        hit;
        logic [31:0] rdata;
        logic [31:0] addr;
        int          issue_cycle;
    } access_t;

    logic                       clk;
    logic                       reset;
    logic                       req;
    dcache_op_e                 op;
    logic [`DCACHE_ADDR_W-1:0]  addr;
    logic [`DCACHE_WORD_W-1:0]  wdata;
    logic [`DCACHE_STRB_W-1:0]  wstrb;
    logic                       busy;
    logic                       resp_valid;
    logic                       resp_hit;
    logic [`DCACHE_WORD_W-1:0]  rdata;
    logic                       mem_rd_req;
    logic [`DCACHE_ADDR_W-1:0]  mem_rd_addr;
    logic                       mem_rd_valid;
    logic [`DCACHE_LINE_W-1:0]  mem_rd_line;
    logic                       mem_wr_req;
    logic [`DCACHE_ADDR_W-1:0]  mem_wr_addr;
    logic [`DCACHE_WORD_W-1:0]  mem_wr_data;
    logic [`DCACHE_STRB_W-1:0]  mem_wr_strb;
    logic                       mem_wr_ack;

    // 4 KB backing store and its reference copy.
    logic [31:0]              mem_model  [MEM_WORDS];
    logic [31:0]              shadow_mem [MEM_WORDS];
    logic [`DCACHE_TAG_W-1:0] shadow_tag [`DCACHE_LINES];
    logic [`DCACHE_LINES-1:0] shadow_valid;

    access_t     exp_q [$];
    access_t     resp_exp;
    int          cycle_count = 0;
    int          checks = 0;
    int          errors = 0;
    logic        reset_q = 1'b0;
    logic [31:0] stim_lfsr;
    logic [31:0] mem_lfsr;

    tb_clock_gen u_clk_gen (
        .clk   (clk),
        .reset (reset)
    );

    dcache_top u_dut (.*);

    // --------------------------------------------------
    // Helpers.
    // --------------------------------------------------
    // Galois LFSR, taps 32 22 2 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken.
    task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_step(state);
            value = {value[30:0], state[0]};
        end
    endtask

    // Every word differs, both halves carry the word address.
    function automatic logic [31:0] fill_word(input int w);
        return {6'h2b, w[9:0], 6'h15, ~w[9:0]};
    endfunction

    function automatic logic [31:0] make_addr(input logic [2:0] tag_lo, input logic [3:0] idx,
                                              input logic [2:0] off);
        return {20'h0, tag_lo, idx, off, 2'b00};
    endfunction

    // Expected {resp_hit, rdata} from the shadow memory and tag table.
    function automatic logic [32:0] ref_access(input dcache_op_e acc_op, input logic [31:0] a,
                                               input logic [31:0] wd, input logic [3:0] ws);
        logic [3:0] idx;
        logic [9:0] w;
        logic       hit;
        idx = a[`DCACHE_INDEX_LSB +: `DCACHE_INDEX_W];
        w   = a[11:2];
        hit = shadow_valid[idx] && (shadow_tag[idx] == a[`DCACHE_TAG_LSB +: `DCACHE_TAG_W]);
        if (acc_op == OP_STORE) begin
            // Stores always reach memory and never allocate.
            for (int b = 0; b < 4; b++) begin
                if (ws[b]) shadow_mem[w][b*8 +: 8] = wd[b*8 +: 8];
            end
            return {hit, 32'h0};
        end
        // A load brings its line in.
        shadow_valid[idx] = 1'b1;
        shadow_tag[idx]   = a[`DCACHE_TAG_LSB +: `DCACHE_TAG_W];
        return {hit, shadow_mem[w]};
    endfunction

    // Pulse req, queue the expectation, wait for the response edge.
    task automatic do_access(input dcache_op_e acc_op, input logic [31:0] a,
                             input logic [31:0] wd, input logic [3:0] ws);
        logic [32:0] expv;
        access_t     entry;
        req   <= 1'b1;
        op    <= acc_op;
        addr  <= a;
        wdata <= wd;
        wstrb <= ws;
        @(posedge clk);
        req  <= 1'b0;
        expv  = ref_access(acc_op, a, wd, ws);
        entry = '{acc_op == OP_STORE, expv[32], expv[31:0], a, cycle_count};
        exp_q.push_back(entry);
        do begin
            @(posedge clk);
        end while (!resp_valid);
    endtask

    // --------------------------------------------------
    // Memory model.
    // --------------------------------------------------
    initial begin : memory_model
        logic [31:0]               bits;
        logic [`DCACHE_LINE_W-1:0] rd_line;
        logic [9:0]                w;
        mem_lfsr     = 32'd52;
        mem_rd_valid = 1'b0;
        mem_rd_line  = '0;
        mem_wr_ack   = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) mem_model[i] = fill_word(i);
        forever begin
            @(posedge clk);
            if (mem_rd_req) begin
                for (int k = 0; k < `DCACHE_WORDS; k++) begin
                    rd_line[k*32 +: 32] = mem_model[{mem_rd_addr[11:5], 3'(k)}];
                end
                // Answer 1 to 4 cycles later.
                draw_bits(mem_lfsr, 2, bits);
                repeat (bits[1:0]) @(posedge clk);
                mem_rd_line  <= rd_line;
                mem_rd_valid <= 1'b1;
                @(posedge clk);
                mem_rd_valid <= 1'b0;
            end else if (mem_wr_req) begin
                w = mem_wr_addr[11:2];
                for (int b = 0; b < 4; b++) begin
                    if (mem_wr_strb[b]) mem_model[w][b*8 +: 8] = mem_wr_data[b*8 +: 8];
                end
                draw_bits(mem_lfsr, 2, bits);
                repeat (bits[1:0]) @(posedge clk);
                mem_wr_ack <= 1'b1;
                @(posedge clk);
                mem_wr_ack <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // Response checker and timeout.
    // --------------------------------------------------
    always @(posedge clk) begin
        // First edge out of reset, the cache must be idle.
        if (reset_q && !reset) begin
            checks++;
            assert (!busy && !resp_valid && !mem_rd_req && !mem_wr_req) else begin
                errors++;
                $display("A control output was high right after reset");
            end
        end
        reset_q <= reset;
        if (!reset && resp_valid) begin
            assert (exp_q.size() > 0) else begin
                errors++;
                $display("A response arrived with no access outstanding");
            end
            if (exp_q.size() > 0) begin
                resp_exp = exp_q.pop_front();
                checks++;
                assert (resp_hit == resp_exp.hit) else begin
                    errors++;
                    $display("FAILED resp_hit at addr %h: got %h, expected %h",
                             resp_exp.addr, resp_hit, resp_exp.hit);
                end
                if (!resp_exp.is_store) begin
                    assert (rdata == resp_exp.rdata) else begin
                        errors++;
                        $display("FAILED rdata at addr %h: got %h, expected %h",
                                 resp_exp.addr, rdata, resp_exp.rdata);
                    end
                end
                if (!resp_exp.is_store && resp_exp.hit) begin
                    assert (cycle_count - resp_exp.issue_cycle == HIT_LATENCY) else begin
                        errors++;
                        $display("Load hit at %h answered after %0d cycles instead of %0d",
                                 resp_exp.addr, cycle_count - resp_exp.issue_cycle, HIT_LATENCY);
                    end
                end
                // Memory must hold the written-through bytes.
                if (resp_exp.is_store) begin
                    assert (mem_model[resp_exp.addr[11:2]] == shadow_mem[resp_exp.addr[11:2]])
                    else begin
                        errors++;
                        $display("FAILED mem_wr_data at addr %h: got %h, expected %h",
                                 resp_exp.addr, mem_model[resp_exp.addr[11:2]],
                                 shadow_mem[resp_exp.addr[11:2]]);
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // --------------------------------------------------
    // Stimulus.
    // --------------------------------------------------
    initial begin : stimulus
        logic [31:0] r_op;
        logic [31:0] r_addr;
        logic [31:0] r_data;
        logic [31:0] r_strb;
        req          = 1'b0;
        op           = OP_LOAD;
        addr         = '0;
        wdata        = '0;
        wstrb        = '0;
        stim_lfsr    = 32'd52;
        shadow_valid = '0;
        for (int i = 0; i < MEM_WORDS; i++) shadow_mem[i] = fill_word(i);
        @(posedge clk);
        while (reset) @(posedge clk);

        // Cold miss on every index, then the same load again.
        for (int i = 0; i < `DCACHE_LINES; i++) begin
            do_access(OP_LOAD, make_addr(3'(i), 4'(i), 3'(i)), 32'h0, 4'h0);
            do_access(OP_LOAD, make_addr(3'(i), 4'(i), 3'(i)), 32'h0, 4'h0);
        end
        // All words of one filled line.
        for (int k = 0; k < `DCACHE_WORDS; k++) begin
            do_access(OP_LOAD, make_addr(3'd3, 4'd3, 3'(k)), 32'h0, 4'h0);
        end
        // Partial store into a cached line.
        do_access(OP_STORE, make_addr(3'd5, 4'd5, 3'd2), 32'hdead_beef, 4'b0101);
        do_access(OP_LOAD, make_addr(3'd5, 4'd5, 3'd2), 32'h0, 4'h0);
        // Store to an uncached line, then load it.
        do_access(OP_STORE, make_addr(3'd2, 4'd7, 3'd4), 32'h1234_5678, 4'b1110);
        do_access(OP_LOAD, make_addr(3'd2, 4'd7, 3'd4), 32'h0, 4'h0);
        // Two tags fight over index 9.
        for (int k = 0; k < 4; k++) begin
            do_access(OP_LOAD, make_addr(3'd4, 4'd9, 3'(k)), 32'h0, 4'h0);
            do_access(OP_LOAD, make_addr(3'd5, 4'd9, 3'(k)), 32'h0, 4'h0);
        end
        // Random loads and stores inside the 4 KB window.
        for (int n = 0; n < RANDOM_ACCESSES; n++) begin
            draw_bits(stim_lfsr, 1, r_op);
            draw_bits(stim_lfsr, 10, r_addr);
            draw_bits(stim_lfsr, 32, r_data);
            draw_bits(stim_lfsr, 4, r_strb);
            do_access(r_op[0] ? OP_STORE : OP_LOAD, {20'h0, r_addr[9:0], 2'b00},
                      r_data, r_strb[3:0]);
        end

        @(posedge clk);
        $display("Summary: %0d checks, %0d errors, %0d accesses outstanding",
                 checks, errors, exp_q.size());
        if (errors == 0 && exp_q.size() == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+common
common/dcache_pkg.sv
common/dcache_array_if.sv
dcache/dcache_array.sv
dcache/dcache_ctrl.sv
rtl/dcache_top.sv
verification/tb_clock_gen.sv
verification/tb_dcache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_dcache \
    -o sim_dcache > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_dcache > sim.log 2>&1 \
    || { cat sim.log; echo "Simulator exited with an error"; exit 1; }

cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
